/* logic/dma_reader.sv */
/*
 * input DMA: issues the A then B read bursts back to back, then packs the
 * returning beats (any interleave of the two ids) into buffer rows
 */
module dma_reader (
    input  logic                        clk,
    input  logic                        rst_n,
    seq_if.reader                       seq,
    input  logic [31:0]                 mat_a_addr_i,
    input  logic [31:0]                 mat_b_addr_i,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    output logic [31:0]                 ar_addr_o,
    output logic                        ar_id_o,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    input  mm_pkg::elem_t               r_data_i,
    input  logic                        r_id_i,
    input  logic                        r_last_i,
    output logic                        buf_a_wren_o,
    output logic                        buf_b_wren_o,
    output logic [mm_pkg::buf_aw-1:0]   buf_waddr_o,
    output mm_pkg::row_t                buf_wdata_o
);

    mm_pkg::rd_state_e state;

    // per-id packing state, indexed by read id
    logic [1:0]                 cnt  [2];
    logic [mm_pkg::buf_aw-1:0]  wrow [2];
    mm_pkg::row_t               sh   [2];
    mm_pkg::row_t               hold [2];
    logic [1:0]                 pend;
    logic [1:0]                 fin;
    logic [1:0]                 wr_en;
    logic                       wsel;
    logic                       beat;
    logic                       load_end;

    // one request at a time, held until ar_ready_i
    assign ar_valid_o = (state == mm_pkg::RD_ADDR_A) || (state == mm_pkg::RD_ADDR_B);
    assign ar_addr_o  = (state == mm_pkg::RD_ADDR_A) ? mat_a_addr_i : mat_b_addr_i;
    assign ar_id_o    = (state == mm_pkg::RD_ADDR_A) ? mm_pkg::id_a : mm_pkg::id_b;
    assign r_ready_o  = (state == mm_pkg::RD_LOAD);
    assign beat       = r_valid_i & r_ready_o;

    // shared write port, A wins a collision and B waits a cycle
    assign wr_en[mm_pkg::id_a] = pend[mm_pkg::id_a];
    assign wr_en[mm_pkg::id_b] = pend[mm_pkg::id_b] & ~pend[mm_pkg::id_a];
    assign wsel         = pend[mm_pkg::id_a] ? mm_pkg::id_a : mm_pkg::id_b;
    assign buf_a_wren_o = wr_en[mm_pkg::id_a];
    assign buf_b_wren_o = wr_en[mm_pkg::id_b];
    assign buf_waddr_o  = wrow[wsel];
    assign buf_wdata_o  = hold[wsel];

    // both bursts ended and this cycle writes the only row still pending
    assign load_end = (&fin) & (^pend);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= mm_pkg::RD_IDLE;
            pend        <= '0;
            fin         <= '0;
            seq.rd_done <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                cnt[i]  <= '0;
                wrow[i] <= '0;
            end
        end else begin
            seq.rd_done <= 1'b0;
            case (state)
                mm_pkg::RD_IDLE:   if (seq.rd_start) state <= mm_pkg::RD_ADDR_A;
                mm_pkg::RD_ADDR_A: if (ar_ready_i) state <= mm_pkg::RD_ADDR_B;
                mm_pkg::RD_ADDR_B: if (ar_ready_i) state <= mm_pkg::RD_LOAD;
                mm_pkg::RD_LOAD: begin
                    if (load_end) begin
                        state       <= mm_pkg::RD_IDLE;
                        seq.rd_done <= 1'b1;
                    end
                end
                default: state <= mm_pkg::RD_IDLE;
            endcase
            // fresh job
            if (seq.rd_start) begin
                fin <= '0;
                for (int i = 0; i < 2; i++) begin
                    cnt[i]  <= '0;
                    wrow[i] <= '0;
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (wr_en[i]) begin
                    pend[i] <= 1'b0;
                    wrow[i] <= wrow[i] + 1'b1;
                end
                if (beat && r_id_i == 1'(i)) begin
                    cnt[i] <= cnt[i] + 1'b1;
                    // fourth beat completes the row
                    if (cnt[i] == 2'(mm_pkg::sa_dim - 1)) pend[i] <= 1'b1;
                    if (r_last_i) fin[i] <= 1'b1;
                end
            end
        end
    end

    // beat k lands in element k, a full row moves to hold until written
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (beat && r_id_i == 1'(i)) begin
                sh[i][cnt[i]] <= r_data_i;
                if (cnt[i] == 2'(mm_pkg::sa_dim - 1)) begin
                    hold[i]                    <= sh[i];
                    hold[i][mm_pkg::sa_dim-1]  <= r_data_i;
                end
            end
        end
    end

endmodule

/* logic/dma_writer.sv */
/*
 * output DMA: one write address, then the 16 C beats in row-major order,
 * then waits for the write response and pulses wr_done on it
 */
module dma_writer (
    input  logic                        clk,
    input  logic                        rst_n,
    seq_if.writer                       seq,
    input  logic [31:0]                 mat_c_addr_i,
    input  mm_pkg::c_tile_t             c_tile_i,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic [31:0]                 aw_addr_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    output logic [mm_pkg::data_w-1:0]   w_data_o,
    output logic                        w_last_o,
    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    mm_pkg::wr_state_e  state;
    logic [3:0]         beat;

    assign aw_valid_o = (state == mm_pkg::WR_ADDR);
    assign aw_addr_o  = mat_c_addr_i;
    assign w_valid_o  = (state == mm_pkg::WR_DATA);
    // beat n carries c[n/4][n%4]
    assign w_data_o   = c_tile_i[beat[3:2]][beat[1:0]];
    assign w_last_o   = (beat == 4'(mm_pkg::burst_beats - 1));
    assign b_ready_o  = (state == mm_pkg::WR_RESP);
    assign seq.wr_done = b_valid_i & b_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mm_pkg::WR_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                mm_pkg::WR_IDLE: begin
                    beat <= '0;
                    if (seq.wr_start) state <= mm_pkg::WR_ADDR;
                end
                mm_pkg::WR_ADDR: if (aw_ready_i) state <= mm_pkg::WR_DATA;
                mm_pkg::WR_DATA: begin
                    // advance only on a transfer, stalls hold the beat
                    if (w_ready_i) begin
                        beat <= beat + 1'b1;
                        if (w_last_o) state <= mm_pkg::WR_RESP;
                    end
                end
                mm_pkg::WR_RESP: if (b_valid_i) state <= mm_pkg::WR_IDLE;
                default: state <= mm_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

/* logic/matmul_array.sv */
/*
 * weight-stationary 4x4 multiply grid. latches the B rows, then streams
 * A rows through and registers one C row per A row. fixed 10-cycle job
 */
module matmul_array (
    input  logic                        clk,
    input  logic                        rst_n,
    seq_if.array                        seq,
    output logic [mm_pkg::buf_aw-1:0]   a_raddr_o,
    input  mm_pkg::row_t                a_rdata_i,
    output logic [mm_pkg::buf_aw-1:0]   b_raddr_o,
    input  mm_pkg::row_t                b_rdata_i,
    output mm_pkg::c_tile_t             c_tile_o
);

    typedef enum logic [1:0] {
        MM_IDLE, MM_LOAD_B, MM_STREAM_A, MM_DRAIN
    } mm_phase_e;

    mm_phase_e                  phase;
    logic [mm_pkg::buf_aw-1:0]  cnt;
    logic [mm_pkg::buf_aw-1:0]  idx_q;
    logic                       ld_b_q;
    logic                       ld_a_q;
    mm_pkg::c_tile_t            w_q;
    mm_pkg::c_tile_t            c_q;
    mm_pkg::row_t               c_row;

    // same counter walks B then A
    assign b_raddr_o = cnt;
    assign a_raddr_o = cnt;
    assign c_tile_o  = c_q;

    // column j sums a[k]*b[k][j], wraps at 32 bits
    always_comb begin
        c_row = '0;
        for (int j = 0; j < mm_pkg::sa_dim; j++) begin
            for (int k = 0; k < mm_pkg::sa_dim; k++) begin
                c_row[j] = c_row[j] + a_rdata_i[k] * w_q[k][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase       <= MM_IDLE;
            cnt         <= '0;
            ld_b_q      <= 1'b0;
            ld_a_q      <= 1'b0;
            seq.mm_done <= 1'b0;
        end else begin
            seq.mm_done <= 1'b0;
            // read data valid one cycle after the address phase
            ld_b_q <= (phase == MM_LOAD_B);
            ld_a_q <= (phase == MM_STREAM_A);
            case (phase)
                MM_IDLE: begin
                    cnt <= '0;
                    if (seq.mm_start) phase <= MM_LOAD_B;
                end
                MM_LOAD_B: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 2'(mm_pkg::sa_dim - 1)) phase <= MM_STREAM_A;
                end
                MM_STREAM_A: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 2'(mm_pkg::sa_dim - 1)) phase <= MM_DRAIN;
                end
                // last C row lands this cycle
                MM_DRAIN: begin
                    phase       <= MM_IDLE;
                    seq.mm_done <= 1'b1;
                end
                default: phase <= MM_IDLE;
            endcase
        end
    end

    // grid weights and result rows
    always_ff @(posedge clk) begin
        idx_q <= cnt;
        if (ld_b_q) w_q[idx_q] <= b_rdata_i;
        if (ld_a_q) c_q[idx_q] <= c_row;
    end

endmodule

/* logic/mm_accel_top.sv */
/*
 * accelerator top: configuration inputs plus AXI-style AR/R/AW/W/B ports.
 * wires the sequencer, both DMA sides, the operand buffers and the array
 */
module mm_accel_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 mat_a_addr_i,
    input  logic [31:0]                 mat_b_addr_i,
    input  logic [31:0]                 mat_c_addr_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    output logic [31:0]                 ar_addr_o,
    output logic                        ar_id_o,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    input  mm_pkg::elem_t               r_data_i,
    input  logic                        r_id_i,
    input  logic                        r_last_i,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic [31:0]                 aw_addr_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    output logic [mm_pkg::data_w-1:0]   w_data_o,
    output logic                        w_last_o,
    input  logic                        b_valid_i,
    output logic                        b_ready_o
);

    logic                       buf_a_wren;
    logic                       buf_b_wren;
    logic [mm_pkg::buf_aw-1:0]  buf_waddr;
    mm_pkg::row_t               buf_wdata;
    logic [mm_pkg::buf_aw-1:0]  a_raddr;
    logic [mm_pkg::buf_aw-1:0]  b_raddr;
    mm_pkg::row_t               a_rdata;
    mm_pkg::row_t               b_rdata;
    mm_pkg::c_tile_t            c_tile;

    seq_if seq0 ();

    mm_sequencer seq_ctl0 (.clk, .rst_n, .start_i, .done_o, .seq(seq0.seq));

    dma_reader rd0 (
        .clk, .rst_n, .seq(seq0.reader), .mat_a_addr_i, .mat_b_addr_i,
        .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_id_o,
        .r_valid_i, .r_ready_o, .r_data_i, .r_id_i, .r_last_i,
        .buf_a_wren_o(buf_a_wren), .buf_b_wren_o(buf_b_wren),
        .buf_waddr_o(buf_waddr), .buf_wdata_o(buf_wdata)
    );

    // A and B share the write address and data, separate enables
    operand_buffer buf_a0 (
        .clk, .wren_i(buf_a_wren), .waddr_i(buf_waddr), .wdata_i(buf_wdata),
        .raddr_i(a_raddr), .rdata_o(a_rdata)
    );

    operand_buffer buf_b0 (
        .clk, .wren_i(buf_b_wren), .waddr_i(buf_waddr), .wdata_i(buf_wdata),
        .raddr_i(b_raddr), .rdata_o(b_rdata)
    );

    matmul_array mm0 (
        .clk, .rst_n, .seq(seq0.array),
        .a_raddr_o(a_raddr), .a_rdata_i(a_rdata),
        .b_raddr_o(b_raddr), .b_rdata_i(b_rdata), .c_tile_o(c_tile)
    );

    dma_writer wr0 (
        .clk, .rst_n, .seq(seq0.writer), .mat_c_addr_i, .c_tile_i(c_tile),
        .aw_valid_o, .aw_ready_i, .aw_addr_o, .w_valid_o, .w_ready_i,
        .w_data_o, .w_last_o, .b_valid_i, .b_ready_o
    );

endmodule

/* logic/mm_pkg.sv */
/*
 * shared sizes, burst rules, read ids and types for the 4x4 matrix
 * multiply accelerator. every design file refers to these by scoped name
 */
package mm_pkg;

    // matrix edge and beat geometry
    localparam int sa_dim      = 4;
    localparam int beat_bytes  = 4;
    localparam int data_w      = beat_bytes * 8;
    localparam int burst_beats = sa_dim * sa_dim;

    // one buffer row holds one matrix row
    localparam int row_w  = sa_dim * data_w;
    localparam int buf_aw = 2;

    // read ids split the two interleaved bursts
    localparam logic id_a = 1'b0;
    localparam logic id_b = 1'b1;

    typedef logic signed [data_w-1:0] elem_t;

    // element 0 sits in the low bits
    typedef elem_t [sa_dim-1:0] row_t;

    // c[i][j], row-major
    typedef row_t [sa_dim-1:0] c_tile_t;

    typedef enum logic [1:0] {
        SEQ_IDLE, SEQ_READ, SEQ_COMPUTE, SEQ_WRITE
    } seq_state_e;

    typedef enum logic [1:0] {
        RD_IDLE, RD_ADDR_A, RD_ADDR_B, RD_LOAD
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE, WR_ADDR, WR_DATA, WR_RESP
    } wr_state_e;

endpackage

/* logic/mm_sequencer.sv */
/*
 * job FSM: accepts start_i while idle, then runs read, compute and write
 * phases in order. done_o is high only while idle
 */
module mm_sequencer (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    output logic      done_o,
    seq_if.seq        seq
);

    mm_pkg::seq_state_e state;

    // idle means no job in flight
    assign done_o = (state == mm_pkg::SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= mm_pkg::SEQ_IDLE;
            seq.rd_start <= 1'b0;
            seq.mm_start <= 1'b0;
            seq.wr_start <= 1'b0;
        end else begin
            // starts are single-cycle pulses
            seq.rd_start <= 1'b0;
            seq.mm_start <= 1'b0;
            seq.wr_start <= 1'b0;
            case (state)
                mm_pkg::SEQ_IDLE: begin
                    if (start_i) begin
                        state        <= mm_pkg::SEQ_READ;
                        seq.rd_start <= 1'b1;
                    end
                end
                mm_pkg::SEQ_READ: begin
                    if (seq.rd_done) begin
                        state        <= mm_pkg::SEQ_COMPUTE;
                        seq.mm_start <= 1'b1;
                    end
                end
                mm_pkg::SEQ_COMPUTE: begin
                    if (seq.mm_done) begin
                        state        <= mm_pkg::SEQ_WRITE;
                        seq.wr_start <= 1'b1;
                    end
                end
                // wr_done comes on the B handshake, done_o follows next cycle
                mm_pkg::SEQ_WRITE: begin
                    if (seq.wr_done) state <= mm_pkg::SEQ_IDLE;
                end
                default: state <= mm_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

/* logic/operand_buffer.sv */
/*
 * four-row operand store, one write port and one registered read port.
 * holds one 4x4 matrix, one row per address
 */
module operand_buffer (
    input  logic                        clk,
    input  logic                        wren_i,
    input  logic [mm_pkg::buf_aw-1:0]   waddr_i,
    input  mm_pkg::row_t                wdata_i,
    input  logic [mm_pkg::buf_aw-1:0]   raddr_i,
    output mm_pkg::row_t                rdata_o
);

    logic [mm_pkg::row_w-1:0] mem [2**mm_pkg::buf_aw];

    always_ff @(posedge clk) begin
        if (wren_i) mem[waddr_i] <= wdata_i;
        // data shows up one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule

/* logic/seq_if.sv */
/*
 * phase start/done pulses between the job sequencer and the reader,
 * the multiply array and the writer. all signals are one-cycle pulses
 */
interface seq_if;

    logic rd_start;
    logic rd_done;
    logic mm_start;
    logic mm_done;
    logic wr_start;
    logic wr_done;

    // sequencer fires the starts and collects the dones
    modport seq (
        output rd_start, mm_start, wr_start,
        input  rd_done, mm_done, wr_done
    );

    modport reader (input rd_start, output rd_done);
    modport array  (input mm_start, output mm_done);
    modport writer (input wr_start, output wr_done);

endinterface

/* mm_accel.f */
logic/mm_pkg.sv
logic/seq_if.sv
logic/mm_sequencer.sv
logic/dma_reader.sv
logic/operand_buffer.sv
logic/matmul_array.sv
logic/dma_writer.sv
logic/mm_accel_top.sv
verif/mm_accel_assert.sv
verif/mm_accel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mm_accel_tb -f mm_accel.f -o mm_accel_sim

./obj_dir/mm_accel_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
grep -q "Test completed successfully" sim.log

/* verif/mm_accel_assert.sv */
/*
 * bound checker for the accelerator top. mirrors the R beats per read id,
 * rebuilds A and B, and checks handshakes, timing and every C beat
 */
module mm_accel_assert (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] mat_a_addr_i,
    input  logic [31:0] mat_b_addr_i,
    input  logic [31:0] mat_c_addr_i,
    input  logic        start_i,
    input  logic        done_o,
    input  logic        ar_valid_o,
    input  logic        ar_ready_i,
    input  logic [31:0] ar_addr_o,
    input  logic        ar_id_o,
    input  logic        r_valid_i,
    input  logic        r_ready_o,
    input  logic [31:0] r_data_i,
    input  logic        r_id_i,
    input  logic        aw_valid_o,
    input  logic        aw_ready_i,
    input  logic [31:0] aw_addr_o,
    input  logic        w_valid_o,
    input  logic        w_ready_i,
    input  logic [31:0] w_data_o,
    input  logic        w_last_o,
    input  logic        b_valid_i,
    input  logic        b_ready_o
);

    int          err_cnt = 0;
    logic [31:0] a_m [16];
    logic [31:0] b_m [16];
    logic [4:0]  r_idx [2];
    logic [4:0]  w_cnt;
    logic [1:0]  ar_cnt;
    logic [31:0] exp_w;
    logic        r_hs;
    logic        w_hs;
    logic        b_hs;

    assign r_hs = r_valid_i & r_ready_o;
    assign w_hs = w_valid_o & w_ready_i;
    assign b_hs = b_valid_i & b_ready_o;

    // mirror of the read data, beat order is row-major per id
    always @(posedge clk) begin
        if (!rst_n) begin
            r_idx[0] <= '0;
            r_idx[1] <= '0;
            w_cnt    <= '0;
            ar_cnt   <= '0;
        end else begin
            if (start_i && done_o) ar_cnt <= '0;
            else if (ar_valid_o && ar_ready_i) ar_cnt <= ar_cnt + 1'b1;
            if (ar_valid_o && ar_ready_i) r_idx[ar_id_o] <= '0;
            if (r_hs) begin
                if (r_id_i) b_m[r_idx[1][3:0]] <= r_data_i;
                else a_m[r_idx[0][3:0]] <= r_data_i;
                r_idx[r_id_i] <= r_idx[r_id_i] + 1'b1;
            end
            if (aw_valid_o && aw_ready_i) w_cnt <= '0;
            else if (w_hs) w_cnt <= w_cnt + 1'b1;
        end
    end

    // expected C[n/4][n%4], wraps at 32 bits
    always_comb begin
        exp_w = '0;
        for (int k = 0; k < 4; k++) begin
            exp_w = exp_w + a_m[{w_cnt[3:2], 2'(k)}] * b_m[{2'(k), w_cnt[1:0]}];
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> !(ar_valid_o || aw_valid_o || w_valid_o || r_ready_o || b_ready_o))
        else begin err_cnt++; $error("valid or ready output high while idle"); end

    done_fall: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && start_i |=> !done_o)
        else begin err_cnt++; $error("done_o did not fall after start_i"); end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_id_o))
        else begin err_cnt++; $error("AR request changed before ar_ready_i"); end

    // first request is A, second is B
    ar_first: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && ar_cnt == 0 |-> ar_id_o == 1'b0 && ar_addr_o == mat_a_addr_i)
        else begin err_cnt++; $error("ERROR ar_addr_o=%h id=%h expected %h id=0",
            $sampled(ar_addr_o), $sampled(ar_id_o), $sampled(mat_a_addr_i)); end

    ar_second: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && ar_cnt == 1 |-> ar_id_o == 1'b1 && ar_addr_o == mat_b_addr_i)
        else begin err_cnt++; $error("ERROR ar_addr_o=%h id=%h expected %h id=1",
            $sampled(ar_addr_o), $sampled(ar_id_o), $sampled(mat_b_addr_i)); end

    aw_addr: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o |-> aw_addr_o == mat_c_addr_i)
        else begin err_cnt++; $error("ERROR aw_addr_o=%h expected %h",
            $sampled(aw_addr_o), $sampled(mat_c_addr_i)); end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_last_o))
        else begin err_cnt++; $error("W beat changed during a w_ready_i stall"); end

    w_data: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> w_data_o == exp_w)
        else begin err_cnt++; $error("ERROR w_data_o=%h expected %h beat %h",
            $sampled(w_data_o), $sampled(exp_w), $sampled(w_cnt)); end

    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> w_last_o == (w_cnt == 5'd15))
        else begin err_cnt++; $error("ERROR w_last_o=%h beat %h",
            $sampled(w_last_o), $sampled(w_cnt)); end

    b_count: assert property (@(posedge clk) disable iff (!rst_n)
        b_hs |-> w_cnt == 5'd16)
        else begin err_cnt++; $error("ERROR w transfers=%h expected 10", $sampled(w_cnt)); end

    done_after_b: assert property (@(posedge clk) disable iff (!rst_n)
        b_hs |=> done_o)
        else begin err_cnt++; $error("done_o not high one cycle after B handshake"); end

    done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_o) |-> $past(b_hs))
        else begin err_cnt++; $error("done_o rose without a B handshake"); end

endmodule

bind mm_accel_top mm_accel_assert chk0 (.*);

/* verif/mm_accel_tb.sv */
/*
 * testbench for the matrix multiply accelerator. a memory model with
 * random stalls and interleaved R beats serves three jobs
 */
module mm_accel_tb;

    localparam int n_jobs    = 3;
    localparam int max_cycle = n_jobs * 300;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] mat_a_addr_i, mat_b_addr_i, mat_c_addr_i;
    logic        start_i, done_o;
    logic        ar_valid_o, ar_ready_i, ar_id_o;
    logic [31:0] ar_addr_o;
    logic        r_valid_i, r_ready_o, r_id_i, r_last_i;
    logic [31:0] r_data_i;
    logic        aw_valid_o, aw_ready_i;
    logic [31:0] aw_addr_o;
    logic        w_valid_o, w_ready_i, w_last_o;
    logic [31:0] w_data_o;
    logic        b_valid_i, b_ready_o;

    // matrices for the current job, row-major
    logic [31:0] a_mat [16];
    logic [31:0] b_mat [16];
    int          rd_seen [2];
    int          rd_wait [2];
    int          rd_idx [2];
    int          b_wait;
    int          b_pend;
    int          cycle = 0;
    int          errors;

    mm_accel_top dut0 (.*);

    always #4 clk = ~clk;

    // memory model
    always @(posedge clk) begin
        int pick;
        int cand;
        if (rst_n) begin
            ar_ready_i <= ($urandom % 4) != 0;
            aw_ready_i <= ($urandom % 3) != 0;
            w_ready_i  <= ($urandom % 4) != 0;
            if (ar_valid_o && ar_ready_i) begin
                rd_seen[ar_id_o] = 1;
                rd_wait[ar_id_o] = $urandom % 6;
                rd_idx[ar_id_o]  = 0;
            end
            // hold a beat until it is taken
            if (!r_valid_i || r_ready_o) begin
                if (r_valid_i) begin
                    rd_idx[r_id_i]++;
                    if (rd_idx[r_id_i] == 16) rd_seen[r_id_i] = 0;
                end
                cand = 0;
                pick = $urandom % 2;
                for (int i = 0; i < 2; i++) begin
                    if (rd_seen[i] != 0 && rd_wait[i] == 0) cand |= 1 << i;
                end
                // fall back to the other id when the pick is not ready
                if (((cand >> pick) & 1) == 0) pick = 1 - pick;
                if (cand != 0 && ($urandom % 3) != 0) begin
                    r_valid_i <= 1'b1;
                    r_id_i    <= 1'(pick);
                    r_data_i  <= pick != 0 ? b_mat[rd_idx[pick]] : a_mat[rd_idx[pick]];
                    r_last_i  <= rd_idx[pick] == 15;
                end else begin
                    r_valid_i <= 1'b0;
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (rd_wait[i] > 0) rd_wait[i]--;
            end
            // write response after a random delay
            if (w_valid_o && w_ready_i && w_last_o) begin
                b_pend = 1;
                b_wait = $urandom % 5;
            end
            if (b_valid_i && b_ready_o) begin
                b_valid_i <= 1'b0;
            end else if (b_pend != 0) begin
                if (b_wait == 0) begin
                    b_valid_i <= 1'b1;
                    b_pend = 0;
                end else begin
                    b_wait--;
                end
            end
        end
    end

    task automatic new_matrices();
        for (int i = 0; i < 16; i++) begin
            a_mat[i] = $urandom;
            b_mat[i] = $urandom;
        end
    endtask

    task automatic wait_done();
        do @(posedge clk); while (!done_o);
    endtask

    // the edge that takes the B handshake is the edge that raises done_o
    task automatic wait_b_handshake();
        do @(posedge clk); while (!(b_valid_i && b_ready_o));
    endtask

    // run limit
    always @(posedge clk) begin
        cycle++;
        if (cycle >= max_cycle) begin
            $display("timeout after %0d cycles, job did not finish", cycle);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h4c03_19c8));
        rst_n        = 1'b0;
        start_i      = 1'b0;
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        ar_ready_i   = 1'b0;
        r_valid_i    = 1'b0;
        r_data_i     = '0;
        r_id_i       = 1'b0;
        r_last_i     = 1'b0;
        aw_ready_i   = 1'b0;
        w_ready_i    = 1'b0;
        b_valid_i    = 1'b0;
        b_pend       = 0;
        b_wait       = 0;
        for (int i = 0; i < 2; i++) begin
            rd_seen[i] = 0;
            rd_wait[i] = 0;
            rd_idx[i]  = 0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // idle period checks the quiet outputs after reset
        repeat (3) @(posedge clk);
        for (int j = 0; j < n_jobs; j++) begin
            // later jobs start in the cycle done_o rises
            if (j == 0) begin
                wait_done();
            end else begin
                wait_b_handshake();
            end
            new_matrices();
            mat_a_addr_i <= 32'h1000_0000 + 32'(j) * 32'h100;
            mat_b_addr_i <= 32'h2000_0000 + 32'(j) * 32'h100;
            mat_c_addr_i <= 32'h3000_0000 + 32'(j) * 32'h100;
            start_i      <= 1'b1;
            @(posedge clk);
            start_i      <= 1'b0;
        end
        wait_done();
        repeat (4) @(posedge clk);
        errors = dut0.chk0.err_cnt;
        $display("errors: %0d assertion failures in %0d cycles", errors, cycle);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
